/* hw/console_ctrl_macros.svh */
`ifndef CONSOLE_CTRL_MACROS_SVH
`define CONSOLE_CTRL_MACROS_SVH

// AXI4-Lite address width
`define AXIL_ADDR_W 8

// register map
`define CMD_ADDR    8'h00
`define CONF_ADDR   8'h04
`define STATUS_ADDR 8'h08

// reset pulse length after reset, in control_clock cycles
`define DEFAULT_HOLD 16'd1000

// counter bits for the LED patterns
`define SLOW_GLOW_BIT 26
`define FAST_GLOW_BIT 22
`define BLINK_BIT     24

`endif

/* hw/console_ctrl_pkg.sv */
package console_ctrl_pkg;

    // front panel LED source
    typedef enum logic [1:0] {
        LED_STATUS = 2'd0,
        LED_OPT    = 2'd1,
        LED_DC     = 2'd2
    } led_mode_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    //////////////////////////////
    // register word, decoded by address

    // command word at CMD_ADDR
    typedef struct packed {
        logic [29:0] reserved;
        logic        opt_reset;
        logic        dc_reset;
    } cmd_word_t;

    // config word at CONF_ADDR
    typedef struct packed {
        logic [7:0]  reserved_hi;
        logic [15:0] hold_cycles;
        logic [5:0]  reserved_lo;
        led_mode_e   led_mode;
    } conf_word_t;

    typedef union packed {
        cmd_word_t  cmd;
        conf_word_t conf;
    } ctrl_word_u;

endpackage

/* hw/console_ctrl_if.sv */
interface console_ctrl_if;
    import console_ctrl_pkg::*;

    // one-cycle request pulses
    logic        dc_req;
    logic        opt_req;

    logic [15:0] hold_cycles;
    led_mode_e   led_mode;

    // reset lines currently held low
    logic        dc_active;
    logic        opt_active;

    modport regs (
        output dc_req, opt_req, hold_cycles, led_mode,
        input  dc_active, opt_active
    );

    modport stretch (
        input  dc_req, opt_req, hold_cycles,
        output dc_active, opt_active
    );

    modport led (
        input led_mode, dc_active, opt_active
    );

endinterface

/* hw/axil_ctrl_regs.sv */
`include "console_ctrl_macros.svh"

module axil_ctrl_regs (
    input  logic                        control_clock,
    input  logic                        reset_dc_out,

    input  logic [`AXIL_ADDR_W-1:0]     s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [31:0]                 s_wdata,
    input  logic                        s_wvalid,
    output logic                        s_wready,
    output console_ctrl_pkg::axi_resp_e s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,

    input  logic [`AXIL_ADDR_W-1:0]     s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [31:0]                 s_rdata,
    output console_ctrl_pkg::axi_resp_e s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready,

    console_ctrl_if.regs                ctrl
);
    import console_ctrl_pkg::*;

    ctrl_word_u  wr_word;
    ctrl_word_u  rd_word;
    logic        wr_accept;
    logic        wr_cmd;
    logic        wr_conf;
    logic        rd_accept;
    logic [31:0] rd_next;
    axi_resp_e   rd_resp;

    logic [15:0] hold_q;
    led_mode_e   mode_q;
    logic        dc_req_q;
    logic        opt_req_q;

    assign ctrl.dc_req      = dc_req_q;
    assign ctrl.opt_req     = opt_req_q;
    assign ctrl.hold_cycles = hold_q;
    assign ctrl.led_mode    = mode_q;

    //////////////////////////////
    // write channel

    // address and data taken together, blocked while a response waits
    assign s_awready = ~s_bvalid;
    assign s_wready  = ~s_bvalid;
    assign wr_accept = s_awvalid & s_wvalid & ~s_bvalid;

    assign wr_word = s_wdata;
    assign wr_cmd  = (s_awaddr == `CMD_ADDR);
    assign wr_conf = (s_awaddr == `CONF_ADDR);

    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            s_bvalid  <= 1'b0;
            dc_req_q  <= 1'b0;
            opt_req_q <= 1'b0;
            hold_q    <= `DEFAULT_HOLD;
            mode_q    <= LED_STATUS;
        end else begin
            dc_req_q  <= 1'b0;
            opt_req_q <= 1'b0;
            if (wr_accept) begin
                s_bvalid <= 1'b1;
                if (wr_cmd) begin
                    dc_req_q  <= wr_word.cmd.dc_reset;
                    opt_req_q <= wr_word.cmd.opt_reset;
                end else if (wr_conf) begin
                    hold_q <= wr_word.conf.hold_cycles;
                    mode_q <= wr_word.conf.led_mode;
                end
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    // status and unmapped offsets are not writable
    always_ff @(posedge control_clock) begin
        if (wr_accept) begin
            s_bresp <= (wr_cmd || wr_conf) ? OKAY : SLVERR;
        end
    end

    //////////////////////////////
    // read channel

    assign s_arready = ~s_rvalid;
    assign rd_accept = s_arvalid & ~s_rvalid;

    always_comb begin
        rd_word = '0;
        rd_next = 32'd0;
        rd_resp = OKAY;
        case (s_araddr)
            `CONF_ADDR: begin
                rd_word.conf.hold_cycles = hold_q;
                rd_word.conf.led_mode    = mode_q;
                rd_next                  = rd_word;
            end
            `STATUS_ADDR: begin
                rd_next = {30'd0, ctrl.opt_active, ctrl.dc_active};
            end
            default: begin
                // command offset reads back as an error too
                rd_resp = SLVERR;
            end
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            s_rvalid <= 1'b0;
        end else if (rd_accept) begin
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge control_clock) begin
        if (rd_accept) begin
            s_rdata <= rd_next;
            s_rresp <= rd_resp;
        end
    end

endmodule

/* hw/reset_stretcher.sv */
module reset_stretcher (
    input  logic        control_clock,
    input  logic        reset_dc_out,
    input  logic        req,
    input  logic [15:0] hold_cycles,
    output logic        drive_low
);

    // cycles left with the line pulled low
    logic [15:0] count;

    // a new request restarts from the current length
    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            count <= 16'd0;
        end else if (req) begin
            count <= hold_cycles;
        end else if (count != 16'd0) begin
            count <= count - 16'd1;
        end
    end

    // open-drain enable, high for exactly the loaded count
    assign drive_low = (count != 16'd0);

endmodule

/* hw/led_glow.sv */
module led_glow #(
    parameter int glow_bit = 22
) (
    input  logic control_clock,
    input  logic reset_dc_out,
    output logic glow
);

    localparam int pwm_w = 8;

    logic [glow_bit:0] count;
    logic [pwm_w-1:0]  ramp;
    logic [pwm_w-1:0]  level;

    // top bit picks the direction, so brightness rises then falls
    assign ramp  = count[glow_bit-1 -: pwm_w];
    assign level = count[glow_bit] ? ~ramp : ramp;

    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            count <= '0;
            glow  <= 1'b0;
        end else begin
            count <= count + 1'b1;
            // duty cycle from the low bits
            glow  <= (count[pwm_w-1:0] < level);
        end
    end

endmodule

/* hw/status_led_ctrl.sv */
`include "console_ctrl_macros.svh"

module status_led_ctrl (
    input  logic       control_clock,
    input  logic       reset_dc_out,
    console_ctrl_if.led ctrl,
    input  logic       pll_ready,
    input  logic       hdmi_ready,
    input  logic       resync,
    input  logic       force_generate,
    output logic       status_led,
    output logic       status_led_oe
);
    import console_ctrl_pkg::*;

    logic                slow_glow_out;
    logic                fast_glow_out;
    logic [`BLINK_BIT:0] blink_count;
    logic                status_level;

    led_glow #(.glow_bit(`SLOW_GLOW_BIT)) slow_glow (
        .control_clock(control_clock),
        .reset_dc_out (reset_dc_out),
        .glow         (slow_glow_out)
    );

    led_glow #(.glow_bit(`FAST_GLOW_BIT)) fast_glow (
        .control_clock(control_clock),
        .reset_dc_out (reset_dc_out),
        .glow         (fast_glow_out)
    );

    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            blink_count <= '0;
        end else begin
            blink_count <= blink_count + 1'b1;
        end
    end

    // video status, LED is active low
    always_comb begin
        if (!pll_ready) begin
            status_level = 1'b1;
        end else if (resync) begin
            status_level = ~fast_glow_out;
        end else if (force_generate) begin
            status_level = blink_count[`BLINK_BIT] ? ~fast_glow_out : 1'b1;
        end else if (hdmi_ready) begin
            status_level = 1'b0;
        end else begin
            status_level = ~slow_glow_out;
        end
    end

    // mirror modes pull the pin low only while the reset line is held
    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            status_led    <= 1'b1;
            status_led_oe <= 1'b1;
        end else begin
            case (ctrl.led_mode)
                LED_STATUS: begin
                    status_led    <= status_level;
                    status_led_oe <= 1'b1;
                end
                LED_DC: begin
                    status_led    <= 1'b0;
                    status_led_oe <= ctrl.dc_active;
                end
                default: begin
                    status_led    <= 1'b0;
                    status_led_oe <= ctrl.opt_active;
                end
            endcase
        end
    end

endmodule

/* hw/console_ctrl_top.sv */
`include "console_ctrl_macros.svh"

module console_ctrl_top (
    input  logic                    control_clock,
    input  logic                    reset_dc_out,

    input  logic [`AXIL_ADDR_W-1:0] s_awaddr,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [31:0]             s_wdata,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output logic [1:0]              s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  logic [`AXIL_ADDR_W-1:0] s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output logic [31:0]             s_rdata,
    output logic [1:0]              s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready,

    // status, already in the control_clock domain
    input  logic                    pll_ready,
    input  logic                    hdmi_ready,
    input  logic                    resync,
    input  logic                    force_generate,

    // drive-low enables for the open-drain pins
    output logic                    dc_reset_drive,
    output logic                    opt_reset_drive,
    output logic                    status_led,
    output logic                    status_led_oe
);

    console_ctrl_if ctrl_bus ();

    axil_ctrl_regs regs (
        .control_clock(control_clock),
        .reset_dc_out (reset_dc_out),
        .s_awaddr     (s_awaddr),
        .s_awvalid    (s_awvalid),
        .s_awready    (s_awready),
        .s_wdata      (s_wdata),
        .s_wvalid     (s_wvalid),
        .s_wready     (s_wready),
        .s_bresp      (s_bresp),
        .s_bvalid     (s_bvalid),
        .s_bready     (s_bready),
        .s_araddr     (s_araddr),
        .s_arvalid    (s_arvalid),
        .s_arready    (s_arready),
        .s_rdata      (s_rdata),
        .s_rresp      (s_rresp),
        .s_rvalid     (s_rvalid),
        .s_rready     (s_rready),
        .ctrl         (ctrl_bus.regs)
    );

    //////////////////////////////
    // reset pulses, each drive also reports back as activity
    reset_stretcher dc_stretch (
        .control_clock(control_clock),
        .reset_dc_out (reset_dc_out),
        .req          (ctrl_bus.dc_req),
        .hold_cycles  (ctrl_bus.hold_cycles),
        .drive_low    (ctrl_bus.dc_active)
    );

    reset_stretcher opt_stretch (
        .control_clock(control_clock),
        .reset_dc_out (reset_dc_out),
        .req          (ctrl_bus.opt_req),
        .hold_cycles  (ctrl_bus.hold_cycles),
        .drive_low    (ctrl_bus.opt_active)
    );

    assign dc_reset_drive  = ctrl_bus.dc_active;
    assign opt_reset_drive = ctrl_bus.opt_active;

    status_led_ctrl led_ctrl (
        .control_clock (control_clock),
        .reset_dc_out  (reset_dc_out),
        .ctrl          (ctrl_bus.led),
        .pll_ready     (pll_ready),
        .hdmi_ready    (hdmi_ready),
        .resync        (resync),
        .force_generate(force_generate),
        .status_led    (status_led),
        .status_led_oe (status_led_oe)
    );

endmodule

/* testbench/console_ctrl_assert.sv */
module console_ctrl_assert (
    input logic control_clock,
    input logic reset_dc_out,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic req,
    input logic drive_low
);
    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions so far
    int fail_count = 0;

    bvalid_held: assert property (@(posedge control_clock) disable iff (reset_dc_out)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    rvalid_held: assert property (@(posedge control_clock) disable iff (reset_dc_out)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    // line only goes low after a request one cycle earlier
    drive_after_req: assert property (@(posedge control_clock) disable iff (reset_dc_out)
        $rose(drive_low) |-> $past(req))
        else begin
            fail_count++;
            $error("drive_low rose without a request");
        end

endmodule

bind axil_ctrl_regs console_ctrl_assert regs_chk (
    .control_clock(control_clock), .reset_dc_out(reset_dc_out),
    .bvalid(s_bvalid), .bready(s_bready), .rvalid(s_rvalid), .rready(s_rready),
    .req(1'b0), .drive_low(1'b0)
);

bind reset_stretcher console_ctrl_assert stretch_chk (
    .control_clock(control_clock), .reset_dc_out(reset_dc_out),
    .bvalid(1'b0), .bready(1'b0), .rvalid(1'b0), .rready(1'b0),
    .req(req), .drive_low(drive_low)
);

/* testbench/console_ctrl_tb.sv */
`include "console_ctrl_macros.svh"

module console_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import console_ctrl_pkg::*;

    localparam int OP_WR = 0, OP_RD = 1, OP_DC_PULSE = 2, OP_OPT_EXTEND = 3;
    localparam int OP_MIRROR = 4, OP_LED = 5;
    localparam int NUM = 15;
    localparam int MAX_HOLD = 20;
    localparam int WAIT_LIMIT = 200;
    localparam int WATCHDOG_NS = (NUM * (4 * MAX_HOLD + 60) + 10) * 4;

    typedef struct {
        int          op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [3:0]  status;
        axi_resp_e   resp;
        logic [31:0] expv;
    } entry_t;

    // status column is {pll_ready, hdmi_ready, resync, force_generate}
    entry_t table_q [NUM] = '{
        '{OP_RD, `CONF_ADDR, 32'h0, 4'b1100, OKAY, 32'h0003_E800},
        '{OP_WR, `CONF_ADDR, 32'h0000_1400, 4'b1100, OKAY, 32'h0},
        '{OP_RD, `CONF_ADDR, 32'h0, 4'b1100, OKAY, 32'h0000_1400},
        '{OP_WR, `STATUS_ADDR, 32'h0000_ff03, 4'b1100, SLVERR, 32'h0},
        '{OP_RD, 8'h0c, 32'h0, 4'b1100, SLVERR, 32'h0},
        '{OP_RD, `CONF_ADDR, 32'h0, 4'b1100, OKAY, 32'h0000_1400},
        '{OP_DC_PULSE, `CMD_ADDR, 32'h1, 4'b1100, OKAY, 32'd20},
        '{OP_OPT_EXTEND, `CMD_ADDR, 32'h2, 4'b1100, OKAY, 32'd20},
        '{OP_WR, `CONF_ADDR, 32'h0000_1402, 4'b1100, OKAY, 32'h0},
        '{OP_MIRROR, `CMD_ADDR, 32'h1, 4'b1100, OKAY, 32'd20},
        '{OP_WR, `CONF_ADDR, 32'h0000_1401, 4'b1100, OKAY, 32'h0},
        '{OP_MIRROR, `CMD_ADDR, 32'h2, 4'b1100, OKAY, 32'd20},
        '{OP_WR, `CONF_ADDR, 32'h0000_1400, 4'b1100, OKAY, 32'h0},
        '{OP_LED, `CMD_ADDR, 32'h0, 4'b0010, OKAY, 32'h1},
        '{OP_LED, `CMD_ADDR, 32'h0, 4'b1100, OKAY, 32'h0}
    };

    logic control_clock = 1'b0;
    logic reset_dc_out;
    logic [7:0] s_awaddr, s_araddr;
    logic [31:0] s_wdata, s_rdata;
    logic [1:0] s_bresp, s_rresp;
    logic s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic s_arvalid, s_arready, s_rvalid, s_rready;
    logic pll_ready, hdmi_ready, resync, force_generate;
    logic dc_reset_drive, opt_reset_drive, status_led, status_led_oe;
    logic [31:0] lfsr_state = 32'hafccb67c;
    int dc_run = 0;
    int dc_len = 0;
    logic opt_seen = 1'b0;

    console_ctrl_top console_ctrl_top_inst (.*);

    always #2 control_clock = ~control_clock;

    // dc pulse length and stray opt activity, sampled away from the active edge
    always @(negedge control_clock) begin
        if (dc_reset_drive) begin
            dc_run = dc_run + 1;
        end else if (dc_run != 0) begin
            dc_len = dc_run;
            dc_run = 0;
        end
        if (opt_reset_drive) opt_seen = 1'b1;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
        if (got !== exp) fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp) fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    // random reserved bits on top of the defined fields
    task automatic add_reserved(input logic [7:0] addr, input logic [31:0] data,
                                output logic [31:0] w);
        logic [31:0] rnd;
        w = data;
        if (addr == `CONF_ADDR || addr == `CMD_ADDR) begin
            random_word(rnd);
            w = data | (rnd & ((addr == `CONF_ADDR) ? 32'hff00_00fc : 32'hffff_fffc));
        end
    endtask

    function automatic int bound_assert_failures();
        return console_ctrl_top_inst.regs.regs_chk.fail_count
            + console_ctrl_top_inst.dc_stretch.stretch_chk.fail_count
            + console_ctrl_top_inst.opt_stretch.stretch_chk.fail_count;
    endfunction

    // called on a falling edge, returns on one
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output axi_resp_e resp);
        int n;
        n = 0;
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        while (!(s_awready && s_wready)) begin
            @(negedge control_clock);
            n++;
            if (n > WAIT_LIMIT) fail_now("write address and data never accepted");
        end
        @(negedge control_clock);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        if (!s_bvalid) fail_now("no write response after accepted write");
        // no new write taken while the response waits
        check_pin("s_awready", s_awready, 1'b0);
        check_pin("s_wready", s_wready, 1'b0);
        resp = axi_resp_e'(s_bresp);
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output axi_resp_e resp);
        int n;
        n = 0;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        while (!s_arready) begin
            @(negedge control_clock);
            n++;
            if (n > WAIT_LIMIT) fail_now("read address never accepted");
        end
        @(negedge control_clock);
        s_arvalid = 1'b0;
        if (!s_rvalid) fail_now("no read data after accepted read");
        check_pin("s_arready", s_arready, 1'b0);
        data = s_rdata;
        resp = axi_resp_e'(s_rresp);
    endtask

    task automatic wait_drive(input bit opt, input logic level, output int n);
        n = 0;
        while ((opt ? opt_reset_drive : dc_reset_drive) !== level) begin
            @(negedge control_clock);
            n++;
            if (n > WAIT_LIMIT) fail_now("reset drive never reached the expected level");
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_now("watchdog expired before the test table finished");
    end

    initial begin
        entry_t      e;
        logic [31:0] wd;
        logic [31:0] rd;
        axi_resp_e   resp;
        int          n;
        reset_dc_out = 1'b1;
        {s_awaddr, s_araddr, s_wdata} = '0;
        {s_awvalid, s_wvalid, s_arvalid} = '0;
        s_bready = 1'b1;
        s_rready = 1'b1;
        {pll_ready, hdmi_ready, resync, force_generate} = 4'b1100;
        repeat (2) @(negedge control_clock);
        reset_dc_out = 1'b0;
        check_pin("dc_reset_drive", dc_reset_drive, 1'b0);
        check_pin("opt_reset_drive", opt_reset_drive, 1'b0);
        check_pin("s_awready", s_awready, 1'b1);
        check_pin("s_wready", s_wready, 1'b1);
        check_pin("s_arready", s_arready, 1'b1);
        check_pin("s_bvalid", s_bvalid, 1'b0);
        check_pin("s_rvalid", s_rvalid, 1'b0);

        for (int i = 0; i < NUM; i++) begin
            e = table_q[i];
            {pll_ready, hdmi_ready, resync, force_generate} = e.status;
            case (e.op)
                OP_WR: begin
                    add_reserved(e.addr, e.data, wd);
                    axi_write(e.addr, wd, resp);
                    check_resp("s_bresp", resp, e.resp);
                end
                OP_RD: begin
                    axi_read(e.addr, rd, resp);
                    check_resp("s_rresp", resp, e.resp);
                    check_data("s_rdata", rd, e.expv);
                end
                OP_DC_PULSE: begin
                    opt_seen = 1'b0;
                    add_reserved(e.addr, e.data, wd);
                    axi_write(e.addr, wd, resp);
                    check_resp("s_bresp", resp, e.resp);
                    wait_drive(1'b0, 1'b1, n);
                    axi_read(`STATUS_ADDR, rd, resp);
                    check_resp("status s_rresp", resp, OKAY);
                    check_data("status s_rdata", rd, 32'h1);
                    wait_drive(1'b0, 1'b0, n);
                    @(negedge control_clock);
                    check_count("dc_reset_drive length", dc_len, e.expv);
                    check_pin("opt_reset_drive seen", opt_seen, 1'b0);
                end
                OP_OPT_EXTEND: begin
                    add_reserved(e.addr, e.data, wd);
                    axi_write(e.addr, wd, resp);
                    check_resp("s_bresp", resp, e.resp);
                    wait_drive(1'b1, 1'b1, n);
                    repeat (5) @(negedge control_clock);
                    add_reserved(e.addr, e.data, wd);
                    axi_write(e.addr, wd, resp);
                    check_resp("s_bresp", resp, e.resp);
                    wait_drive(1'b1, 1'b0, n);
                    check_count("opt_reset_drive length", n - 1, e.expv);
                end
                OP_MIRROR: begin
                    add_reserved(e.addr, e.data, wd);
                    axi_write(e.addr, wd, resp);
                    check_resp("s_bresp", resp, e.resp);
                    // drive high on cycles 1..hold, LED enable one cycle later
                    for (int k = 1; k <= 2 * e.expv + 4; k++) begin
                        @(negedge control_clock);
                        if (e.data[1]) begin
                            check_pin("opt_reset_drive", opt_reset_drive, k <= e.expv);
                        end else begin
                            check_pin("dc_reset_drive", dc_reset_drive, k <= e.expv);
                        end
                        check_pin("status_led", status_led, 1'b0);
                        check_pin("status_led_oe", status_led_oe, k >= 2 && k <= e.expv + 1);
                    end
                end
                default: begin
                    repeat (2) @(negedge control_clock);
                    check_pin("status_led", status_led, e.expv[0]);
                    check_pin("status_led_oe", status_led_oe, 1'b1);
                end
            endcase
        end
        if (bound_assert_failures() != 0) begin
            fail_now("bound assertion checker reported a failure");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* sources.f */
+incdir+hw
hw/console_ctrl_pkg.sv
hw/console_ctrl_if.sv
hw/axil_ctrl_regs.sv
hw/reset_stretcher.sv
hw/led_glow.sv
hw/status_led_ctrl.sv
hw/console_ctrl_top.sv
testbench/console_ctrl_assert.sv
testbench/console_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module console_ctrl_tb \
    -f sources.f -o console_ctrl_sim \
    && ./obj_dir/console_ctrl_sim | grep "TEST PASS" \
    && exit 0 \
    || exit 1
